// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_vector_bus
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
source/vector_pkg.sv
source/clock_enables.sv
source/wait_state_gen.sv
source/bus_status_decoder.sv
source/retrace_irq.sv
source/palette_port.sv
source/rom_shadow_ctl.sv
source/vector_bus_top.sv
testbench/tb_vector_bus.sv

// File: source/bus_status_decoder.sv
//////////////////////////////
// Status word latch and registered I/O port decode into selects and strobes
//////////////////////////////
`timescale 1ns/1ps

module bus_status_decoder (
	input  logic                     clk24,
	input  logic                     RESET_n,
	input  logic                     cpu_ce,
	input  logic                     sync,
	input  logic                     wr_n,
	input  logic [7:0]               cpu_do,
	input  logic [7:0]               cpu_a,
	output vector_pkg::status_word_t status,
	output logic [1:0]               port_lo,
	output logic                     vm55_cs,
	output logic                     vi53_wren,
	output logic                     vi53_rden,
	output logic                     ramdisk_write,
	output logic                     iports_write
);
	import vector_pkg::*;

	logic [7:0] addr_r;
	logic [5:0] port_dev;
	logic       io_rd;
	logic       io_wr;
	logic       wr;

	//////////////////////////////
	// Status and address latches
	//////////////////////////////
	// Status byte is on the data bus during the sync tick
	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			status <= '0;
		end else if (cpu_ce && sync) begin
			status.raw <= cpu_do;
		end
	end

	// I/O address, refreshed every CPU tick
	always_ff @(posedge clk24) begin
		if (cpu_ce) begin
			addr_r <= cpu_a;
		end
	end

	//////////////////////////////
	// Port decode
	//////////////////////////////
	assign port_dev = addr_r[7:2];
	assign io_rd    = status.flags.inp;
	assign io_wr    = status.flags.out;
	// Write data valid on the bus
	assign wr       = ~wr_n;

	// Internal 8255, ports 00..03
	assign vm55_cs = (io_rd | io_wr) & (port_dev == PORT_VM55);

	// 8253 timer, ports 08..0B
	assign vi53_wren = wr & io_wr & (port_dev == PORT_VI53);
	assign vi53_rden = io_rd & (port_dev == PORT_VI53);

	// RAM-disk bank register
	assign ramdisk_write = wr & io_wr & (addr_r == PORT_RAMDISK);

	// Internal ports 0C..0F
	assign iports_write = wr & io_wr & (port_dev == PORT_IPORTS);

	// Peripherals see register index inverted
	assign port_lo = ~addr_r[1:0];

endmodule

// File: source/clock_enables.sv
//////////////////////////////
// Clock enables: 12, 6 and 3 MHz strobes plus video slot level from clk24
//////////////////////////////
`timescale 1ns/1ps

module clock_enables (
	input  logic clk24,
	input  logic RESET_n,
	output logic ce12,
	output logic ce6,
	output logic cpu_ce,
	output logic video_slice
);
	import vector_pkg::*;

	// One 8-cycle bus window
	logic [CE_DIV_BITS-1:0] div_cnt;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Enable decode
	//////////////////////////////
	// Every 2nd cycle
	assign ce12 = div_cnt[0];
	// Every 4th cycle
	assign ce6 = &div_cnt[1:0];
	// Every 8th, last cycle of the window
	assign cpu_ce = &div_cnt;

	// First half of the window belongs to video fetch
	assign video_slice = ~div_cnt[CE_DIV_BITS-1];

endmodule

// File: source/palette_port.sv
//////////////////////////////
// Palette port 0C colour byte capture and palette RAM write strobe
//////////////////////////////
`timescale 1ns/1ps

module palette_port (
	input  logic       clk24,
	input  logic       RESET_n,
	input  logic       cpu_ce,
	input  logic       iports_write,
	input  logic [1:0] port_lo,
	input  logic [7:0] data,
	output logic [7:0] palette_value,
	output logic       palette_wren
);
	logic palette_hit;

	// Inverted port_lo 11 means address bits 00
	assign palette_hit = cpu_ce & iports_write & (port_lo == 2'b11);

	// Colour byte from the CPU data bus
	always_ff @(posedge clk24) begin
		if (palette_hit) begin
			palette_value <= data;
		end
	end

	// One clk24 strobe per write
	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			palette_wren <= 1'b0;
		end else begin
			palette_wren <= palette_hit;
		end
	end

endmodule

// File: source/retrace_irq.sv
//////////////////////////////
// Frame interrupt: delayed, fixed-width request after the retrace rise
//////////////////////////////
`timescale 1ns/1ps

module retrace_irq (
	input  logic clk24,
	input  logic RESET_n,
	input  logic cpu_ce,
	input  logic retrace,
	output logic int_request
);
	import vector_pkg::*;

	logic                    retrace_d;
	logic                    retrace_rise;
	logic                    active;
	logic [IRQ_CNT_BITS-1:0] tick_cnt;

	assign retrace_rise = retrace & ~retrace_d;

	// Delay phase then request phase on one counter
	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			retrace_d   <= 1'b0;
			active      <= 1'b0;
			tick_cnt    <= '0;
			int_request <= 1'b0;
		end else if (cpu_ce) begin
			retrace_d <= retrace;
			if (!active) begin
				// Arm on rise, tick zero
				if (retrace_rise) begin
					active   <= 1'b1;
					tick_cnt <= '0;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
				if (tick_cnt == IRQ_CNT_BITS'(IRQ_DELAY_TICKS - 1)) begin
					int_request <= 1'b1;
				end
				// Request window over
				if (tick_cnt == IRQ_CNT_BITS'(IRQ_DELAY_TICKS + IRQ_WIDTH_TICKS - 1)) begin
					int_request <= 1'b0;
					active      <= 1'b0;
				end
			end
		end
	end

endmodule

// File: source/rom_shadow_ctl.sv
//////////////////////////////
// BLK+SBR: sticky boot ROM disable and timed CPU reset pulse
//////////////////////////////
`timescale 1ns/1ps

module rom_shadow_ctl (
	input  logic clk24,
	input  logic RESET_n,
	input  logic cpu_ce,
	input  logic blksbr_key,
	output logic disable_rom,
	output logic blksbr_reset
);
	import vector_pkg::*;

	logic                    key_d;
	logic [BLK_CNT_BITS-1:0] pulse_cnt;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			key_d        <= 1'b0;
			disable_rom  <= 1'b0;
			blksbr_reset <= 1'b0;
			pulse_cnt    <= '0;
		end else if (cpu_ce) begin
			key_d <= blksbr_key;
			// Stays off until next reset
			if (blksbr_key) begin
				disable_rom <= 1'b1;
			end
			if (blksbr_reset) begin
				pulse_cnt <= pulse_cnt + 1'b1;
				if (pulse_cnt == BLK_CNT_BITS'(BLKSBR_PULSE_TICKS - 1)) begin
					blksbr_reset <= 1'b0;
				end
			end else if (blksbr_key && !key_d) begin
				// New press only
				blksbr_reset <= 1'b1;
				pulse_cnt    <= '0;
			end
		end
	end

endmodule

// File: source/vector_bus_top.sv
//////////////////////////////
// Bus-control core top: clock enables, wait states, port decode, IRQ, BLK+SBR
//////////////////////////////
`timescale 1ns/1ps

module vector_bus_top (
	input  logic                     clk24,
	input  logic                     RESET_n,
	input  logic                     sync,
	input  logic                     wr_n,
	input  logic [7:0]               cpu_do,
	input  logic [7:0]               cpu_a,
	input  logic                     retrace,
	input  logic                     blksbr_key,
	output logic                     cpu_ce,
	output logic                     ce12,
	output logic                     ce6,
	output logic                     video_slice,
	output logic                     ready,
	output vector_pkg::status_word_t status,
	output logic [1:0]               port_lo,
	output logic                     vm55_cs,
	output logic                     vi53_wren,
	output logic                     vi53_rden,
	output logic                     ramdisk_write,
	output logic [7:0]               palette_value,
	output logic                     palette_wren,
	output logic                     int_request,
	output logic                     disable_rom,
	output logic                     blksbr_reset
);
	// Decoder to palette
	logic iports_write;

	//////////////////////////////
	// Clocking and wait states
	//////////////////////////////
	clock_enables u_clock_enables (
		.clk24      (clk24),
		.RESET_n    (RESET_n),
		.ce12       (ce12),
		.ce6        (ce6),
		.cpu_ce     (cpu_ce),
		.video_slice(video_slice)
	);

	wait_state_gen u_wait_state_gen (
		.clk24  (clk24),
		.RESET_n(RESET_n),
		.cpu_ce (cpu_ce),
		.sync   (sync),
		.status (status),
		.ready  (ready)
	);

	//////////////////////////////
	// I/O ports
	//////////////////////////////
	bus_status_decoder u_bus_status_decoder (
		.clk24        (clk24),
		.RESET_n      (RESET_n),
		.cpu_ce       (cpu_ce),
		.sync         (sync),
		.wr_n         (wr_n),
		.cpu_do       (cpu_do),
		.cpu_a        (cpu_a),
		.status       (status),
		.port_lo      (port_lo),
		.vm55_cs      (vm55_cs),
		.vi53_wren    (vi53_wren),
		.vi53_rden    (vi53_rden),
		.ramdisk_write(ramdisk_write),
		.iports_write (iports_write)
	);

	// Colour byte comes straight off the CPU data bus
	palette_port u_palette_port (
		.clk24        (clk24),
		.RESET_n      (RESET_n),
		.cpu_ce       (cpu_ce),
		.iports_write (iports_write),
		.port_lo      (port_lo),
		.data         (cpu_do),
		.palette_value(palette_value),
		.palette_wren (palette_wren)
	);

	//////////////////////////////
	// Interrupt and BLK+SBR
	//////////////////////////////
	retrace_irq u_retrace_irq (
		.clk24      (clk24),
		.RESET_n    (RESET_n),
		.cpu_ce     (cpu_ce),
		.retrace    (retrace),
		.int_request(int_request)
	);

	rom_shadow_ctl u_rom_shadow_ctl (
		.clk24       (clk24),
		.RESET_n     (RESET_n),
		.cpu_ce      (cpu_ce),
		.blksbr_key  (blksbr_key),
		.disable_rom (disable_rom),
		.blksbr_reset(blksbr_reset)
	);

endmodule

// File: source/vector_pkg.sv
//////////////////////////////
// Bus-control shared types: status word, I/O port codes and tick counts
//////////////////////////////
package vector_pkg;

	//////////////////////////////
	// 8080 status word
	//////////////////////////////
	// Same byte seen raw or as flags, MSB first
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic memr;
			logic inp;
			logic m1;
			logic out;
			logic hlta;
			logic stack;
			logic wo_n;
			logic inta;
		} flags;
	} status_word_t;

	// Device field, address bits 7..2
	localparam logic [5:0] PORT_VM55   = 6'd0;
	localparam logic [5:0] PORT_VI53   = 6'd2;
	localparam logic [5:0] PORT_IPORTS = 6'd3;
	// Full address of the RAM-disk control port
	localparam logic [7:0] PORT_RAMDISK = 8'h10;

	// Divider and slot counter widths
	localparam int CE_DIV_BITS = 3;
	localparam int WS_CNT_BITS = 5;

	// Timings in cpu_ce ticks
	localparam int IRQ_DELAY_TICKS    = 36;
	localparam int IRQ_WIDTH_TICKS    = 8;
	localparam int BLKSBR_PULSE_TICKS = 4;
	// Tick counter widths
	localparam int IRQ_CNT_BITS = $clog2(IRQ_DELAY_TICKS + IRQ_WIDTH_TICKS);
	localparam int BLK_CNT_BITS = $clog2(BLKSBR_PULSE_TICKS);

endpackage

// File: source/wait_state_gen.sv
//////////////////////////////
// Wait states: holds READY low for CPU memory cycles outside the CPU slot
//////////////////////////////
`timescale 1ns/1ps

module wait_state_gen (
	input  logic                    clk24,
	input  logic                    RESET_n,
	input  logic                    cpu_ce,
	input  logic                    sync,
	input  vector_pkg::status_word_t status,
	output logic                    ready
);
	import vector_pkg::*;

	logic [WS_CNT_BITS-1:0] ws_cnt;
	logic                   cpu_time;
	logic                   ws_req;
	logic                   sync_hit;

	// Free slot counter
	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			ws_cnt <= '0;
		end else begin
			ws_cnt <= ws_cnt + 1'b1;
		end
	end

	// CPU owns counts 28..31
	assign cpu_time = &ws_cnt[WS_CNT_BITS-1 -: 3];

	// Memory read or non-OUT write wants the bus
	assign ws_req = (status.flags.memr | ~status.flags.wo_n) & ~status.flags.out;

	//////////////////////////////
	// READY latch
	//////////////////////////////
	// Status register lags the sync edge by one clk24 cycle,
	// so the request is judged on the cycle right after it
	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			sync_hit <= 1'b0;
			ready    <= 1'b1;
		end else begin
			sync_hit <= cpu_ce & sync & ~cpu_time;
			if (sync_hit && ws_req) begin
				ready <= 1'b0;
			end
			// Slot open, release the CPU
			if (cpu_time) begin
				ready <= 1'b1;
			end
		end
	end

endmodule

// File: testbench/tb_vector_bus.sv
//////////////////////////////
// Testbench for the bus-control core with decode, palette, wait-state, IRQ and BLK+SBR checks
//////////////////////////////
`timescale 1ns/1ps

module tb_vector_bus;
	import vector_pkg::*;

	// Longest wait on any single event in clk24 cycles
	localparam int TIMEOUT_CYCLES = 64;

	logic         clk24;
	logic         RESET_n;
	logic         sync;
	logic         wr_n;
	logic [7:0]   cpu_do;
	logic [7:0]   cpu_a;
	logic         retrace;
	logic         blksbr_key;
	logic         cpu_ce;
	logic         ce12;
	logic         ce6;
	logic         video_slice;
	logic         ready;
	status_word_t status;
	logic [1:0]   port_lo;
	logic         vm55_cs;
	logic         vi53_wren;
	logic         vi53_rden;
	logic         ramdisk_write;
	logic [7:0]   palette_value;
	logic         palette_wren;
	logic         int_request;
	logic         disable_rom;
	logic         blksbr_reset;

	int           error_count;
	int           timeout_count;
	integer       seed;
	// Free slot position from reset
	logic [4:0]   slot_cnt;

	vector_bus_top dut0 (.*);

	initial begin
		clk24 = 1'b0;
	end
	always #20 clk24 = ~clk24;

	always @(posedge clk24) begin
		if (!RESET_n) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 5'd1;
		end
	end

	//////////////////////////////
	// Reference functions
	//////////////////////////////
	// Flag order from the top bit down
	function automatic logic flag_bit(input logic [7:0] b, input string name);
		case (name)
			"memr":  return b[7];
			"inp":   return b[6];
			"m1":    return b[5];
			"out":   return b[4];
			"hlta":  return b[3];
			"stack": return b[2];
			"wo_n":  return b[1];
			"inta":  return b[0];
			default: return 1'bx;
		endcase
	endfunction

	// Memory read or a write that is not OUT
	function automatic logic wait_request(input logic [7:0] st);
		return (flag_bit(st, "memr") | ~flag_bit(st, "wo_n")) & ~flag_bit(st, "out");
	endfunction

	// {vm55_cs, vi53_wren, vi53_rden, ramdisk_write}
	function automatic logic [3:0] expected_strobes(input logic [7:0] addr,
			input logic [7:0] st, input logic wn);
		logic rd;
		logic wr_io;
		logic we;
		rd = flag_bit(st, "inp");
		wr_io = flag_bit(st, "out");
		we = ~wn;
		return {(rd | wr_io) & (addr[7:2] == PORT_VM55),
			we & wr_io & (addr[7:2] == PORT_VI53),
			rd & (addr[7:2] == PORT_VI53),
			we & wr_io & (addr == PORT_RAMDISK)};
	endfunction

	// Tick of the request rise or of its end
	function automatic int irq_edge_tick(input logic falling);
		return falling ? IRQ_DELAY_TICKS + IRQ_WIDTH_TICKS : IRQ_DELAY_TICKS;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic check_status(input string name, input status_word_t exp,
			input status_word_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp.raw, act.raw);
			error_count++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			error_count++;
		end
	endtask

	//////////////////////////////
	// Bus helpers
	//////////////////////////////
	// Just past the next rising edge
	task automatic step();
		@(posedge clk24);
		#2;
	endtask

	// Ends inside the next cycle with cpu_ce high
	// n counts the cycles taken
	task automatic wait_cpu_ce(output int n);
		step();
		n = 1;
		while (cpu_ce !== 1'b1 && n < TIMEOUT_CYCLES) begin
			step();
			n++;
		end
		if (cpu_ce !== 1'b1) begin
			$display("Timeout while waiting for cpu_ce to go high");
			timeout_count++;
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (ready !== 1'b1 && n < TIMEOUT_CYCLES) begin
			step();
			n++;
		end
		if (ready !== 1'b1) begin
			$display("Timeout while waiting for ready to return high");
			timeout_count++;
		end
	endtask

	// Status with sync on one CPU tick then data and wr_n
	task automatic bus_cycle(input logic [7:0] st, input logic [7:0] addr,
			input logic [7:0] data, input logic wn, output logic in_window);
		int n;
		wait_cpu_ce(n);
		sync = 1'b1;
		cpu_do = st;
		cpu_a = addr;
		// CPU owns slots 28..31
		in_window = (slot_cnt[4:2] == 3'b111);
		step();
		sync = 1'b0;
		cpu_do = data;
		wr_n = wn;
	endtask

	// Tick counts of a pulse rise and fall from the tick just passed
	task automatic measure_pulse(input logic sel_blk, input int max_ticks,
			output int rise, output int fall);
		int   ticks;
		int   n;
		logic prev_ce;
		logic level;
		ticks = 0;
		n = 0;
		rise = -1;
		fall = -1;
		prev_ce = cpu_ce;
		level = sel_blk ? blksbr_reset : int_request;
		if (level) begin
			rise = 0;
		end
		while (ticks < max_ticks && n < max_ticks * 8 + TIMEOUT_CYCLES) begin
			step();
			n++;
			if (prev_ce) begin
				ticks++;
			end
			prev_ce = cpu_ce;
			level = sel_blk ? blksbr_reset : int_request;
			if (level && rise < 0) begin
				rise = ticks;
			end
			if (!level && rise >= 0 && fall < 0) begin
				fall = ticks;
			end
		end
		if (ticks < max_ticks) begin
			$display("Timeout while counting CPU ticks of a pulse");
			timeout_count++;
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		logic [31:0]  r;
		logic [7:0]   st;
		logic [7:0]   addr;
		logic [7:0]   data;
		logic         wn;
		logic         win;
		logic         saw_low;
		logic [3:0]   exp_s;
		status_word_t exp_st;
		int           n;
		int           cnt;
		int           ce12_cnt;
		int           ce6_cnt;
		int           video_cnt;
		int           rise;
		int           fall;
		RESET_n = 1'b0;
		sync = 1'b0;
		wr_n = 1'b1;
		cpu_do = 8'h00;
		cpu_a = 8'h00;
		retrace = 1'b0;
		blksbr_key = 1'b0;
		error_count = 0;
		timeout_count = 0;
		seed = 32'h8f23;
		repeat (16) @(posedge clk24);
		#2;
		RESET_n = 1'b1;

		// Reset state
		check_bit("reset_ready", 1'b1, ready);
		check_bit("reset_vm55_cs", 1'b0, vm55_cs);
		check_bit("reset_vi53_wren", 1'b0, vi53_wren);
		check_bit("reset_vi53_rden", 1'b0, vi53_rden);
		check_bit("reset_ramdisk_write", 1'b0, ramdisk_write);
		check_bit("reset_palette_wren", 1'b0, palette_wren);
		check_bit("reset_int_request", 1'b0, int_request);
		check_bit("reset_disable_rom", 1'b0, disable_rom);
		check_bit("reset_blksbr_reset", 1'b0, blksbr_reset);
		wait_cpu_ce(n);
		check_byte("first_cpu_ce", 8'd7, 8'(n));
		repeat (3) begin
			wait_cpu_ce(n);
			check_byte("cpu_ce_spacing", 8'd8, 8'(n));
		end

		// Faster enables and video slot over one bus window
		ce12_cnt = 0;
		ce6_cnt = 0;
		video_cnt = 0;
		repeat (8) begin
			step();
			if (ce12) begin
				ce12_cnt++;
			end
			if (ce6) begin
				ce6_cnt++;
			end
			if (video_slice) begin
				video_cnt++;
			end
		end
		check_byte("ce12_per_window", 8'd4, 8'(ce12_cnt));
		check_byte("ce6_per_window", 8'd2, 8'(ce6_cnt));
		check_byte("video_slice_per_window", 8'd4, 8'(video_cnt));

		// Status latch in raw and flag views
		repeat (16) begin
			r = $random(seed);
			st = r[7:0];
			bus_cycle(st, 8'hFF, 8'h00, 1'b1, win);
			exp_st.raw = st;
			check_status("status", exp_st, status);
			check_bit("flag_memr", flag_bit(st, "memr"), status.flags.memr);
			check_bit("flag_inp", flag_bit(st, "inp"), status.flags.inp);
			check_bit("flag_m1", flag_bit(st, "m1"), status.flags.m1);
			check_bit("flag_out", flag_bit(st, "out"), status.flags.out);
			check_bit("flag_hlta", flag_bit(st, "hlta"), status.flags.hlta);
			check_bit("flag_stack", flag_bit(st, "stack"), status.flags.stack);
			check_bit("flag_wo_n", flag_bit(st, "wo_n"), status.flags.wo_n);
			check_bit("flag_inta", flag_bit(st, "inta"), status.flags.inta);
		end

		// Port decode mostly in the low 32 ports where devices live
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			addr = r[8] ? {3'b000, r[4:0]} : r[7:0];
			st = r[9] ? 8'h10 : 8'h42;
			wn = r[10];
			// Lead with a RAM-disk control write
			if (i == 0) begin
				addr = PORT_RAMDISK;
				st = 8'h10;
				wn = 1'b0;
			end
			bus_cycle(st, addr, r[23:16], wn, win);
			#10;
			exp_s = expected_strobes(addr, st, wn);
			check_bit("vm55_cs", exp_s[3], vm55_cs);
			check_bit("vi53_wren", exp_s[2], vi53_wren);
			check_bit("vi53_rden", exp_s[1], vi53_rden);
			check_bit("ramdisk_write", exp_s[0], ramdisk_write);
			check_byte("port_lo", {6'd0, ~addr[1:0]}, {6'd0, port_lo});
			step();
			wr_n = 1'b1;
		end

		// Palette write to 0C strobes on the following CPU tick
		r = $random(seed);
		data = r[7:0];
		bus_cycle(8'h10, 8'h0C, data, 1'b0, win);
		wait_cpu_ce(n);
		cnt = 0;
		repeat (10) begin
			step();
			// Write ends after its CPU tick
			wr_n = 1'b1;
			if (palette_wren) begin
				cnt++;
			end
		end
		check_byte("palette_wren_cycles", 8'd1, 8'(cnt));
		check_byte("palette_value", data, palette_value);
		// Port 0D must leave the palette alone
		bus_cycle(8'h10, 8'h0D, ~data, 1'b0, win);
		wait_cpu_ce(n);
		cnt = 0;
		repeat (10) begin
			step();
			wr_n = 1'b1;
			if (palette_wren) begin
				cnt++;
			end
		end
		check_byte("palette_0d_wren_cycles", 8'd0, 8'(cnt));
		check_byte("palette_0d_value", data, palette_value);

		// Memory reads across several slots
		repeat (4) begin
			wait_ready();
			bus_cycle(8'h82, 8'h00, 8'h00, 1'b1, win);
			saw_low = 1'b0;
			repeat (6) begin
				step();
				if (!ready) begin
					saw_low = 1'b1;
				end
			end
			check_bit("ready_stall_mem_read", wait_request(8'h82) & ~win, saw_low);
		end
		wait_ready();
		// OUT cycles never stall
		repeat (4) begin
			bus_cycle(8'h10, 8'h20, 8'h55, 1'b0, win);
			saw_low = 1'b0;
			repeat (8) begin
				step();
				if (!ready) begin
					saw_low = 1'b1;
				end
			end
			wr_n = 1'b1;
			check_bit("ready_stall_out", 1'b0, saw_low);
		end

		// Retrace interrupt timing
		wait_cpu_ce(n);
		retrace = 1'b1;
		step();
		measure_pulse(1'b0, IRQ_DELAY_TICKS + IRQ_WIDTH_TICKS + 4, rise, fall);
		check_byte("irq_delay_ticks", 8'(irq_edge_tick(1'b0)), 8'(rise));
		check_byte("irq_end_tick", 8'(irq_edge_tick(1'b1)), 8'(fall));
		check_byte("irq_width_ticks", 8'(IRQ_WIDTH_TICKS), 8'(fall - rise));
		retrace = 1'b0;

		// BLK+SBR press, pulse and sticky disable
		wait_cpu_ce(n);
		blksbr_key = 1'b1;
		step();
		check_bit("disable_rom_set", 1'b1, disable_rom);
		measure_pulse(1'b1, BLKSBR_PULSE_TICKS + 4, rise, fall);
		check_byte("blksbr_rise_tick", 8'd0, 8'(rise));
		check_byte("blksbr_width_ticks", 8'(BLKSBR_PULSE_TICKS), 8'(fall));
		blksbr_key = 1'b0;
		repeat (3) wait_cpu_ce(n);
		step();
		check_bit("disable_rom_sticky", 1'b1, disable_rom);
		check_bit("blksbr_reset_idle", 1'b0, blksbr_reset);

		$display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
